/* igr_top.f */
+incdir+design
design/igr_pkg.sv
design/igr_tag_if.sv
design/igr_port_rx.sv
design/igr_tag_arb.sv
design/igr_top.sv
verif/igr_assert.sv
verif/igr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f igr_top.f --top-module igr_tb -o igr_sim \
  && ./obj_dir/igr_sim | tee /dev/stderr | grep -F "All tests passed" > /dev/null \
  && { echo "Simulation run ok"; exit 0; } \
  || { echo "Simulation run not ok"; exit 1; }

/* verif/igr_tb.sv */
// Ingress stage testbench: frame stimulus, tag scoreboard, credit return and summary
`timescale 1ns/1ps

`include "igr_settings.svh"

module igr_tb;

  localparam int MAX     = `IGR_MAX_LEN;
  localparam int CREDITS = `IGR_TAG_CREDITS;
  // All six tests fit in well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int IDLE_LIMIT     = 200;

  logic                                       ingress_clock;
  logic                                       arst_n;
  logic [`IGR_NUM_PORTS-1:0]                  rx_valid;
  logic [`IGR_NUM_PORTS-1:0]                  rx_sop;
  logic [`IGR_NUM_PORTS-1:0]                  rx_eop;
  logic [`IGR_NUM_PORTS-1:0][`IGR_DATA_W-1:0] rx_data;
  logic                                       tag_valid;
  logic [`IGR_PORT_W-1:0]                     tag_port;
  igr_pkg::frame_class_e                      tag_class;
  logic [`IGR_LEN_W-1:0]                      tag_len;
  logic                                       tag_err;
  logic                                       tag_credit;
  logic [`IGR_NUM_PORTS-1:0][`IGR_DROP_W-1:0] drop_count;

  // Scoreboard and consumer state
  igr_pkg::tag_t exp_q[$];
  int            due_q[$];
  int            cycle = 0;
  int            tags_seen = 0;
  int            errors = 0;
  int            err_start = 0;
  int            n_ok = 0;
  int            n_bad = 0;
  logic          credit_en;
  logic [31:0]   rng;
  string         cur_test;

  igr_top DUT (
    .ingress_clock (ingress_clock),
    .arst_n        (arst_n),
    .rx_valid      (rx_valid),
    .rx_sop        (rx_sop),
    .rx_eop        (rx_eop),
    .rx_data       (rx_data),
    .tag_valid     (tag_valid),
    .tag_port      (tag_port),
    .tag_class     (tag_class),
    .tag_len       (tag_len),
    .tag_err       (tag_err),
    .tag_credit    (tag_credit),
    .drop_count    (drop_count)
  );

  bind igr_top igr_assert u_assert (
    .ingress_clock (ingress_clock),
    .arst_n        (arst_n),
    .tag_valid     (tag_valid),
    .tag_len       (tag_len),
    .tag_err       (tag_err),
    .tag_credit    (tag_credit)
  );

  initial begin
    ingress_clock = 1'b0;
    forever #10 ingress_clock = ~ingress_clock;
  end

  // Cycle count and run limit
  always @(posedge ingress_clock) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle, cur_test);
      $display("Some tests failed");
      $finish;
    end
  end

  // ====================
  // Consumer model
  // ====================
  // Tags sampled mid-cycle, each owes a credit three cycles on
  always @(negedge ingress_clock) begin
    if (arst_n && tag_valid) begin
      tags_seen++;
      due_q.push_back(cycle + 3);
      check_tag();
    end
  end

  // Credits held back while disabled, then returned one per cycle
  always @(posedge ingress_clock) begin
    #2;
    if (credit_en && (due_q.size() > 0) && (due_q[0] <= cycle)) begin
      tag_credit = 1'b1;
      void'(due_q.pop_front());
    end else begin
      tag_credit = 1'b0;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Oldest expected tag of the same port must match
  task automatic check_tag();
    igr_pkg::tag_t act;
    int            hit;
    act.port = tag_port;
    act.cls  = tag_class;
    act.len  = tag_len;
    act.err  = tag_err;
    hit = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if ((hit < 0) && (exp_q[i].port == tag_port)) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      $display("Unexpected tag from port %0d in test %s", tag_port, cur_test);
      errors++;
    end else begin
      assert (act == exp_q[hit]) else begin
        $display("Error %s: expected %h, actual %h", cur_test, exp_q[hit], act);
        errors++;
      end
      exp_q.delete(hit);
    end
  endtask

  // ====================
  // Stimulus
  // ====================
  // Entered and left 2 ns after a rising edge
  task automatic send_frame(input int port, input igr_pkg::frame_class_e cls,
                            input int len, input bit expect_tag = 1'b1);
    logic [31:0]   word;
    igr_pkg::tag_t exp;
    exp.port = `IGR_PORT_W'(port);
    exp.cls  = cls;
    exp.len  = (len > MAX) ? `IGR_LEN_W'(MAX) : `IGR_LEN_W'(len);
    exp.err  = (len > MAX);
    for (int i = 0; i < len; i++) begin
      rng  = xorshift32(rng);
      word = rng;
      // Class rides in the top two bits of the sop word
      if (i == 0) begin
        word[31:30] = cls;
      end
      rx_valid[port] = 1'b1;
      rx_sop[port]   = (i == 0);
      rx_eop[port]   = (i == len - 1);
      rx_data[port]  = word;
      if ((i == len - 1) && expect_tag) begin
        exp_q.push_back(exp);
      end
      @(posedge ingress_clock);
      #2;
    end
    rx_valid[port] = 1'b0;
    rx_sop[port]   = 1'b0;
    rx_eop[port]   = 1'b0;
  endtask

  // Drain all expected tags and owed credits
  task automatic wait_idle();
    int n;
    n = 0;
    while (((exp_q.size() != 0) || (due_q.size() != 0)) && (n < IDLE_LIMIT)) begin
      @(posedge ingress_clock);
      #2;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected tags never arrived in test %s", exp_q.size(), cur_test);
      errors++;
      exp_q.delete();
    end
    repeat (3) @(posedge ingress_clock);
    #2;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    if (errors == err_start) begin
      $display("%-12s ok", cur_test);
      n_ok++;
    end else begin
      $display("%-12s FAILED with %0d errors", cur_test, errors - err_start);
      n_bad++;
    end
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    int mark;
    int n;
    rx_valid   = '0;
    rx_sop     = '0;
    rx_eop     = '0;
    rx_data    = '0;
    tag_credit = 1'b0;
    credit_en  = 1'b1;
    arst_n     = 1'b0;
    rng        = 32'hcb8f_7648;
    cur_test   = "reset";
    repeat (16) @(posedge ingress_clock);
    #2;
    arst_n = 1'b1;

    start_test("reset");
    assert (tag_valid == 1'b0) else begin
      $display("Error reset: expected tag_valid 0, actual %b", tag_valid);
      errors++;
    end
    for (int p = 0; p < `IGR_NUM_PORTS; p++) begin
      assert (drop_count[p] == '0) else begin
        $display("Error reset: expected drop_count 0, actual %0d", drop_count[p]);
        errors++;
      end
    end
    end_test();

    // Every class shows up across the ports
    start_test("class_len");
    for (int p = 0; p < `IGR_NUM_PORTS; p++) begin
      send_frame(p, igr_pkg::frame_class_e'((p + 0) % 4), 1);
      send_frame(p, igr_pkg::frame_class_e'((p + 1) % 4), 5);
      send_frame(p, igr_pkg::frame_class_e'((p + 2) % 4), MAX);
    end
    wait_idle();
    end_test();

    start_test("oversize");
    send_frame(2, igr_pkg::MCAST, MAX + 7);
    wait_idle();
    end_test();

    // Four eops on the same edge
    start_test("fairness");
    fork
      send_frame(0, igr_pkg::UCAST, 3);
      send_frame(1, igr_pkg::MCAST, 3);
      send_frame(2, igr_pkg::BCAST, 3);
      send_frame(3, igr_pkg::CTRL, 3);
    join
    wait_idle();
    end_test();

    start_test("credit_stall");
    credit_en = 1'b0;
    mark = tags_seen;
    for (int i = 0; i < CREDITS + 2; i++) begin
      send_frame(i % 4, igr_pkg::BCAST, 2);
    end
    // Window in which no further tag may appear
    repeat (10) @(posedge ingress_clock);
    #2;
    assert (tags_seen - mark == CREDITS) else begin
      $display("Error credit_stall: expected %0d, actual %0d", CREDITS, tags_seen - mark);
      errors++;
    end
    credit_en = 1'b1;
    wait_idle();
    end_test();

    // Port 0 uses up the credits, then port 1 overflows its queue
    start_test("overflow");
    credit_en = 1'b0;
    mark = tags_seen;
    for (int i = 0; i < CREDITS; i++) begin
      send_frame(0, igr_pkg::UCAST, 2);
    end
    n = 0;
    while ((tags_seen - mark < CREDITS) && (n < IDLE_LIMIT)) begin
      @(posedge ingress_clock);
      #2;
      n++;
    end
    if (tags_seen - mark < CREDITS) begin
      $display("Initial credits were not used up in test %s", cur_test);
      errors++;
    end
    for (int i = 0; i < `IGR_TAG_QUEUE + 2; i++) begin
      send_frame(1, igr_pkg::CTRL, 2, i < `IGR_TAG_QUEUE);
    end
    repeat (2) @(posedge ingress_clock);
    #2;
    for (int p = 0; p < `IGR_NUM_PORTS; p++) begin
      assert (drop_count[p] == ((p == 1) ? 8'd2 : 8'd0)) else begin
        $display("Error overflow: expected %0d, actual %0d", (p == 1) ? 2 : 0, drop_count[p]);
        errors++;
      end
    end
    credit_en = 1'b1;
    wait_idle();
    end_test();

    $display("Tests: %0d ok, %0d failed, %0d check errors, %0d assertion failures",
             n_ok, n_bad, errors, DUT.u_assert.assert_fails);
    if ((n_bad == 0) && (DUT.u_assert.assert_fails == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verif/igr_assert.sv */
// Bound checks on the ingress tag output: reset quiet, length field and credit balance
`timescale 1ns/1ps

`include "igr_settings.svh"

module igr_assert (
  input logic                  ingress_clock,
  input logic                  arst_n,
  input logic                  tag_valid,
  input logic [`IGR_LEN_W-1:0] tag_len,
  input logic                  tag_err,
  input logic                  tag_credit
);

  localparam int MAX_LEN = `IGR_MAX_LEN;
  localparam int CREDITS = `IGR_TAG_CREDITS;

  // Failures so far, read by the testbench summary
  int assert_fails = 0;
  // Tags delivered minus credits returned, from the ports only
  int outstanding;

  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + (tag_valid ? 1 : 0) - (tag_credit ? 1 : 0);
    end
  end

  // ====================
  // Output rules
  // ====================
  a_reset_quiet: assert property (@(posedge ingress_clock) !arst_n |-> !tag_valid)
    else begin
      assert_fails++;
      $error("tag_valid high while in reset");
    end

  a_len_limit: assert property (@(posedge ingress_clock) disable iff (!arst_n)
    tag_valid |-> (int'(tag_len) <= MAX_LEN))
    else begin
      assert_fails++;
      $error("tag_len above the frame length limit");
    end

  // Oversize tags carry the saturated length
  a_err_len: assert property (@(posedge ingress_clock) disable iff (!arst_n)
    (tag_valid && tag_err) |-> (int'(tag_len) == MAX_LEN))
    else begin
      assert_fails++;
      $error("tag_err set with tag_len not at the limit");
    end

  a_credit_bal: assert property (@(posedge ingress_clock) disable iff (!arst_n)
    (outstanding >= 0) && (outstanding <= CREDITS))
    else begin
      assert_fails++;
      $error("more tags in flight than credits granted");
    end

endmodule

/* design/igr_top.sv */
// Ingress stage top: per-port receivers merged onto one credit-controlled tag output
`timescale 1ns/1ps

`include "igr_settings.svh"

module igr_top (
  input  logic                                          ingress_clock,
  input  logic                                          arst_n,
  // Line side, one lane per port
  input  logic [`IGR_NUM_PORTS-1:0]                     rx_valid,
  input  logic [`IGR_NUM_PORTS-1:0]                     rx_sop,
  input  logic [`IGR_NUM_PORTS-1:0]                     rx_eop,
  input  logic [`IGR_NUM_PORTS-1:0][`IGR_DATA_W-1:0]    rx_data,
  // Tag output
  output logic                                          tag_valid,
  output logic [`IGR_PORT_W-1:0]                        tag_port,
  output igr_pkg::frame_class_e                         tag_class,
  output logic [`IGR_LEN_W-1:0]                         tag_len,
  output logic                                          tag_err,
  input  logic                                          tag_credit,
  // Per-port drop counters
  output logic [`IGR_NUM_PORTS-1:0][`IGR_DROP_W-1:0]    drop_count
);

  igr_pkg::tag_t tag_out;

  // One queue-to-arbiter link per port
  igr_tag_if tag_if [`IGR_NUM_PORTS] ();

  // ====================
  // Port receivers
  // ====================
  for (genvar p = 0; p < `IGR_NUM_PORTS; p++) begin : g_port
    igr_port_rx u_port_rx (
      .ingress_clock (ingress_clock),
      .arst_n        (arst_n),
      .rx_valid      (rx_valid[p]),
      .rx_sop        (rx_sop[p]),
      .rx_eop        (rx_eop[p]),
      .rx_data       (rx_data[p]),
      .tag_q         (tag_if[p]),
      .drop_count    (drop_count[p])
    );
  end

  // ====================
  // Tag arbiter
  // ====================
  igr_tag_arb u_tag_arb (
    .ingress_clock (ingress_clock),
    .arst_n        (arst_n),
    .tag_a         (tag_if),
    .tag_credit    (tag_credit),
    .tag_valid     (tag_valid),
    .tag_out       (tag_out)
  );

  // Descriptor split onto plain ports
  assign tag_port  = tag_out.port;
  assign tag_class = tag_out.cls;
  assign tag_len   = tag_out.len;
  assign tag_err   = tag_out.err;

endmodule

/* design/igr_tag_arb.sv */
// Round-robin tag arbiter with output credit counter and registered tag output
`timescale 1ns/1ps

`include "igr_settings.svh"

module igr_tag_arb (
  input  logic            ingress_clock,
  input  logic            arst_n,
  // One link per port queue
  igr_tag_if.arb          tag_a [`IGR_NUM_PORTS],
  // Downstream returns one credit per consumed tag
  input  logic            tag_credit,
  output logic            tag_valid,
  output igr_pkg::tag_t   tag_out
);

  localparam int CRW = $clog2(`IGR_TAG_CREDITS + 1);
  localparam logic [CRW-1:0]         CREDIT_MAX = CRW'(`IGR_TAG_CREDITS);
  localparam logic [`IGR_PORT_W-1:0] LAST_PORT  = `IGR_PORT_W'(`IGR_NUM_PORTS - 1);

  // Flattened view of the links
  logic [`IGR_NUM_PORTS-1:0]  req_vec;
  logic [`IGR_NUM_PORTS-1:0]  grant_vec;
  igr_pkg::frame_class_e      cls_arr [`IGR_NUM_PORTS];
  logic [`IGR_LEN_W-1:0]      len_arr [`IGR_NUM_PORTS];
  logic [`IGR_NUM_PORTS-1:0]  err_vec;

  // Arbitration
  logic [`IGR_PORT_W-1:0]     last_q;
  logic [`IGR_PORT_W-1:0]     pick;
  logic                       found;
  logic                       grant_en;
  logic [CRW-1:0]             credit_q;

  for (genvar i = 0; i < `IGR_NUM_PORTS; i++) begin : g_link
    assign req_vec[i]     = tag_a[i].req;
    assign cls_arr[i]     = tag_a[i].cls;
    assign len_arr[i]     = tag_a[i].len;
    assign err_vec[i]     = tag_a[i].err;
    assign tag_a[i].grant = grant_vec[i];
  end

  // ====================
  // Round-robin pick
  // ====================
  // First requester after the last granted port
  always_comb begin
    int unsigned idx;
    pick  = '0;
    found = 1'b0;
    for (int k = 1; k <= `IGR_NUM_PORTS; k++) begin
      idx = (int'(last_q) + k) % `IGR_NUM_PORTS;
      if (!found && req_vec[idx]) begin
        found = 1'b1;
        pick  = idx[`IGR_PORT_W-1:0];
      end
    end
  end

  // No credit, no grant
  assign grant_en  = found && (credit_q != '0);
  assign grant_vec = grant_en ? (`IGR_NUM_PORTS'(1) << pick) : '0;

  // Pointer moves only on a grant
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      // Port 0 gets first turn
      last_q <= LAST_PORT;
    end else if (grant_en) begin
      last_q <= pick;
    end
  end

  // ====================
  // Credit counter
  // ====================
  // Grant and credit return in one cycle cancel out
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      credit_q <= CREDIT_MAX;
    end else begin
      case ({grant_en, tag_credit})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: begin
          // Excess returns are ignored
          if (credit_q != CREDIT_MAX) begin
            credit_q <= credit_q + 1'b1;
          end
        end
        default: credit_q <= credit_q;
      endcase
    end
  end

  // ====================
  // Tag output
  // ====================
  // Granted head plus its port index, one cycle after the grant
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      tag_valid <= 1'b0;
      tag_out   <= '0;
    end else begin
      tag_valid <= grant_en;
      if (grant_en) begin
        tag_out.port <= pick;
        tag_out.cls  <= cls_arr[pick];
        tag_out.len  <= len_arr[pick];
        tag_out.err  <= err_vec[pick];
      end
    end
  end

endmodule

/* design/igr_port_rx.sv */
// Ingress port receiver: frame tracking, classification, length count, tag queue and drops
`timescale 1ns/1ps

`include "igr_settings.svh"

module igr_port_rx (
  input  logic                         ingress_clock,
  input  logic                         arst_n,
  // Line-side word stream, no back-pressure
  input  logic                         rx_valid,
  input  logic                         rx_sop,
  input  logic                         rx_eop,
  input  logic [`IGR_DATA_W-1:0]       rx_data,
  // Head of tag queue towards the arbiter
  igr_tag_if.queue                     tag_q,
  // Tags lost to a full queue, saturating
  output logic [`IGR_DROP_W-1:0]       drop_count
);

  localparam int QW = (`IGR_TAG_QUEUE > 1) ? $clog2(`IGR_TAG_QUEUE) : 1;
  localparam int FW = $clog2(`IGR_TAG_QUEUE + 1);
  localparam logic [`IGR_LEN_W-1:0] MAX_LEN  = `IGR_LEN_W'(`IGR_MAX_LEN);
  localparam logic [QW-1:0]         LAST_IDX = QW'(`IGR_TAG_QUEUE - 1);
  localparam logic [FW-1:0]         DEPTH    = FW'(`IGR_TAG_QUEUE);

  // Frame tracker
  igr_pkg::port_state_e   state_q, state_d;
  igr_pkg::frame_class_e  cls_q, cls_d;
  logic [`IGR_LEN_W-1:0]  cnt_q, cnt_d;
  logic                   err_d;
  logic                   accept;

  // Tag queue
  igr_pkg::frame_class_e  q_cls [`IGR_TAG_QUEUE];
  logic [`IGR_LEN_W-1:0]  q_len [`IGR_TAG_QUEUE];
  logic                   q_err [`IGR_TAG_QUEUE];
  logic [QW-1:0]          wr_ptr;
  logic [QW-1:0]          rd_ptr;
  logic [FW-1:0]          fill;
  logic                   full;
  logic                   push;
  logic                   pop;
  logic                   drop;

  // ====================
  // Frame tracking
  // ====================
  // Word belongs to a frame: either a sop, or inside one
  // Stray words outside a frame are ignored
  assign accept = rx_valid && (rx_sop || (state_q != igr_pkg::IDLE));

  always_comb begin
    state_d = state_q;
    cls_d   = cls_q;
    cnt_d   = cnt_q;
    err_d   = 1'b0;
    if (accept) begin
      if (rx_sop) begin
        // New frame, a sop mid-frame restarts it
        cls_d   = igr_pkg::frame_class_e'(rx_data[`IGR_DATA_W-1 -: 2]);
        cnt_d   = `IGR_LEN_W'(1);
        state_d = igr_pkg::BODY;
      end else if ((state_q == igr_pkg::OVERSIZE) || (cnt_q == MAX_LEN)) begin
        // Past the limit, length saturates and err sticks
        cnt_d   = MAX_LEN;
        err_d   = 1'b1;
        state_d = igr_pkg::OVERSIZE;
      end else begin
        cnt_d   = cnt_q + 1'b1;
        state_d = igr_pkg::BODY;
      end
      // Frame closes on eop whatever it was
      if (rx_eop) begin
        state_d = igr_pkg::IDLE;
      end
    end
  end

  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= igr_pkg::IDLE;
      cls_q   <= igr_pkg::UCAST;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cls_q   <= cls_d;
      cnt_q   <= cnt_d;
    end
  end

  // ====================
  // Tag queue
  // ====================
  assign full = (fill == DEPTH);
  assign push = accept && rx_eop && !full;
  assign drop = accept && rx_eop && full;
  // Arbiter only grants a requesting queue
  assign pop  = tag_q.grant;

  // Entry storage, written on the eop edge
  always_ff @(posedge ingress_clock) begin
    if (push) begin
      q_cls[wr_ptr] <= cls_d;
      q_len[wr_ptr] <= cnt_d;
      q_err[wr_ptr] <= err_d;
    end
  end

  // Circular pointers and fill level
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Head entry towards the arbiter, req from the cycle after the push
  assign tag_q.req = (fill != '0);
  assign tag_q.cls = q_cls[rd_ptr];
  assign tag_q.len = q_len[rd_ptr];
  assign tag_q.err = q_err[rd_ptr];

  // ====================
  // Drop counter
  // ====================
  // Holds at all ones
  always_ff @(posedge ingress_clock or negedge arst_n) begin
    if (!arst_n) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

/* design/igr_tag_if.sv */
// Per-port tag request/grant link between a port's tag queue and the arbiter
`timescale 1ns/1ps

`include "igr_settings.svh"

interface igr_tag_if;

  // Queue non-empty, fields below show the head entry
  logic                     req;
  // One-cycle pulse, pops the head in the same cycle
  logic                     grant;
  // Head entry fields
  igr_pkg::frame_class_e    cls;
  logic [`IGR_LEN_W-1:0]    len;
  logic                     err;

  // Tag queue side
  modport queue (
    output req,
    output cls,
    output len,
    output err,
    input  grant
  );

  // Arbiter side
  modport arb (
    input  req,
    input  cls,
    input  len,
    input  err,
    output grant
  );

endinterface

/* design/igr_pkg.sv */
// Ingress stage types: frame class, receiver state and the tag descriptor

`include "igr_settings.svh"

package igr_pkg;

  // ====================
  // Frame class
  // ====================
  // Taken from the top two bits of the sop word
  typedef enum logic [1:0] {
    UCAST = 2'b00,
    MCAST = 2'b01,
    BCAST = 2'b10,
    CTRL  = 2'b11
  } frame_class_e;

  // ====================
  // Receiver state
  // ====================
  // IDLE between frames, BODY while counting, OVERSIZE past the limit
  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    BODY     = 2'b01,
    OVERSIZE = 2'b10
  } port_state_e;

  // ====================
  // Tag descriptor
  // ====================
  // One finished frame, as seen on the tag output
  typedef struct packed {
    logic [`IGR_PORT_W-1:0] port;
    frame_class_e           cls;
    logic [`IGR_LEN_W-1:0]  len;
    logic                   err;  // Frame was longer than IGR_MAX_LEN
  } tag_t;

endpackage

/* design/igr_settings.svh */
// Ingress stage settings: port count, field widths, length limit, queue and credit sizes
`ifndef IGR_SETTINGS_SVH
`define IGR_SETTINGS_SVH

// ====================
// Port and line side
// ====================
// Receive ports into the ingress stage
`define IGR_NUM_PORTS   4
// Bits needed to number a port
`define IGR_PORT_W      2
// Line word width, class sits in the top two bits of the sop word
`define IGR_DATA_W      32

// ====================
// Tag side
// ====================
// Length field in a tag, wide enough for IGR_MAX_LEN
`define IGR_LEN_W       6
// Longest legal frame in words
`define IGR_MAX_LEN     32
// Tags held per port before frames are dropped
`define IGR_TAG_QUEUE   4
// Credits granted by the downstream after reset
`define IGR_TAG_CREDITS 4
// Per-port drop counter width, saturating
`define IGR_DROP_W      8

`endif
